// File: common/memop_pkg.sv
// Shared definitions for the memory operation engine.
// Register offsets assume a 4-bit APB address with one 32-bit word per register.
package memop_pkg;

    // ----------------------------------------
    // command opcodes
    // ----------------------------------------
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_ADD   = 2'd2,
        OP_FILL  = 2'd3
    } memop_opcode_e;

    // ----------------------------------------
    // APB register map
    // ----------------------------------------
    localparam logic [3:0] REG_CMD    = 4'h0;
    localparam logic [3:0] REG_WDATA  = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;
    localparam logic [3:0] REG_RDATA  = 4'hC;

    // ----------------------------------------
    // command word fields
    // ----------------------------------------
    // opcode in 1..0, address in 15..8, fill length in 31..16
    localparam int CMD_OP_LSB   = 0;
    localparam int CMD_ADDR_LSB = 8;
    localparam int CMD_LEN_LSB  = 16;

    localparam int CMD_OP_WIDTH  = 2;
    localparam int CMD_LEN_WIDTH = 16;

    // bus data width seen by the host
    localparam int APB_DATA_WIDTH = 32;

endpackage

// File: src/ram_simple_dualport.sv
// Simple dual-port RAM, one write port and one read port on separate clocks.
// Read data appears one cycle after rd_en, or two with DOUT_REGS set.
// No reset on the array or the output registers.
`timescale 1ns/1ps
`default_nettype none

module ram_simple_dualport #(
    parameter int                    ADDR_WIDTH   = 8,
    parameter int                    DATA_WIDTH   = 32,
    parameter int                    DOUT_REGS    = 0,
    parameter bit                    FILLMEM      = 1'b0,
    parameter logic [DATA_WIDTH-1:0] FILLMEM_DATA = '0
) (
    // write side
    input  logic                  wr_clk,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_din,

    // read side
    input  logic                  rd_clk,
    input  logic                  rd_en,
    input  logic                  rd_regcke,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0] rd_dout
);

    localparam int MEM_SIZE = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [MEM_SIZE];
    logic [DATA_WIDTH-1:0] rd_q;

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_din;
        end
    end

    // ----------------------------------------
    // read port
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    // optional output register, loads only under rd_regcke
    if (DOUT_REGS != 0) begin : g_dout_reg
        logic [DATA_WIDTH-1:0] dout_q;

        always_ff @(posedge rd_clk) begin
            if (rd_regcke) begin
                dout_q <= rd_q;
            end
        end

        assign rd_dout = dout_q;
    end else begin : g_dout_direct
        assign rd_dout = rd_q;
    end

    // power-up contents
    initial begin
        if (FILLMEM) begin
            for (int i = 0; i < MEM_SIZE; i++) begin
                mem[i] = FILLMEM_DATA;
            end
        end
    end

endmodule

`default_nettype wire

// File: memop_engine/memop_decode.sv
// APB slave for the engine. pready is tied high, no wait states.
// A command write while busy (or while a command is being issued) is dropped
// and answered with pslverr. REG_CMD reads back as zero.
`timescale 1ns/1ps
`default_nettype none

module memop_decode #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                                       rd_clk,
    input  logic                                       rst_n,

    // APB
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [3:0]                                 paddr,
    input  logic [memop_pkg::APB_DATA_WIDTH-1:0]       pwdata,
    output logic [memop_pkg::APB_DATA_WIDTH-1:0]       prdata,
    output logic                                       pready,
    output logic                                       pslverr,

    // engine status
    input  logic                                       busy,
    input  logic [DATA_WIDTH-1:0]                      last_rdata,

    // command issue
    output logic                                       cmd_valid,
    output memop_pkg::memop_opcode_e                   cmd_op,
    output logic [ADDR_WIDTH-1:0]                      cmd_addr,
    output logic [memop_pkg::CMD_LEN_WIDTH-1:0]        cmd_len,
    output logic [DATA_WIDTH-1:0]                      cmd_data
);

    logic                  apb_write;
    logic                  cmd_hit;
    logic                  cmd_accept;
    logic [DATA_WIDTH-1:0] wdata_q;

    // ----------------------------------------
    // access decode
    // ----------------------------------------
    assign apb_write  = psel && penable && pwrite;
    assign cmd_hit    = apb_write && (paddr == memop_pkg::REG_CMD);
    // cmd_valid cycle counts as busy, busy itself rises one cycle later
    assign cmd_accept = cmd_hit && !busy && !cmd_valid;

    assign pready  = 1'b1;
    assign pslverr = cmd_hit && (busy || cmd_valid);

    // control and operand register
    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
            wdata_q   <= '0;
        end else begin
            cmd_valid <= cmd_accept;
            if (apb_write && (paddr == memop_pkg::REG_WDATA)) begin
                wdata_q <= pwdata[DATA_WIDTH-1:0];
            end
        end
    end

    // command fields, held for the whole command
    always_ff @(posedge rd_clk) begin
        if (cmd_accept) begin
            cmd_op   <= memop_pkg::memop_opcode_e'(
                pwdata[memop_pkg::CMD_OP_LSB +: memop_pkg::CMD_OP_WIDTH]);
            cmd_addr <= pwdata[memop_pkg::CMD_ADDR_LSB +: ADDR_WIDTH];
            cmd_len  <= pwdata[memop_pkg::CMD_LEN_LSB +: memop_pkg::CMD_LEN_WIDTH];
            // snapshot so later WDATA writes do not disturb a running command
            cmd_data <= wdata_q;
        end
    end

    // ----------------------------------------
    // read data mux
    // ----------------------------------------
    always_comb begin
        prdata = '0;
        case (paddr)
            memop_pkg::REG_WDATA: begin
                prdata[DATA_WIDTH-1:0] = wdata_q;
            end
            memop_pkg::REG_STATUS: begin
                prdata[0] = busy;
            end
            memop_pkg::REG_RDATA: begin
                prdata[DATA_WIDTH-1:0] = last_rdata;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: memop_engine/memop_execute.sv
// Command sequencer driving the RAM ports, one command at a time.
// Read latency is not counted here, the FSM waits for rd_valid.
// Fill addresses wrap at the RAM size, a zero length writes one word.
`timescale 1ns/1ps
`default_nettype none

module memop_execute #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                                rd_clk,
    input  logic                                rst_n,

    // command from decode
    input  logic                                cmd_valid,
    input  memop_pkg::memop_opcode_e            cmd_op,
    input  logic [ADDR_WIDTH-1:0]               cmd_addr,
    input  logic [memop_pkg::CMD_LEN_WIDTH-1:0] cmd_len,
    input  logic [DATA_WIDTH-1:0]               cmd_data,
    output logic                                busy,

    // RAM ports
    output logic                                wr_en,
    output logic [ADDR_WIDTH-1:0]               wr_addr,
    output logic [DATA_WIDTH-1:0]               wr_din,
    output logic                                rd_en,
    output logic [ADDR_WIDTH-1:0]               rd_addr,
    output logic                                rd_regcke,

    // read return path
    output logic                                rd_issue,
    input  logic                                rd_valid,
    input  logic [DATA_WIDTH-1:0]               rd_data
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        READ_WAIT,
        ADD_WRITE,
        FILL
    } state_e;

    state_e                              state;
    logic [memop_pkg::CMD_LEN_WIDTH-1:0] fill_left;

    assign busy = (state != IDLE);

    // ----------------------------------------
    // FSM and port strobes
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            wr_en     <= 1'b0;
            rd_en     <= 1'b0;
            rd_regcke <= 1'b0;
            rd_issue  <= 1'b0;
        end else begin
            // output register follows every real read by one cycle
            rd_regcke <= rd_en;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        case (cmd_op)
                            memop_pkg::OP_WRITE: begin
                                state <= WRITE;
                                wr_en <= 1'b1;
                            end
                            memop_pkg::OP_FILL: begin
                                state <= FILL;
                                wr_en <= 1'b1;
                            end
                            // read and add both start with a read
                            default: begin
                                state    <= READ_WAIT;
                                rd_en    <= 1'b1;
                                rd_issue <= 1'b1;
                            end
                        endcase
                    end
                end
                WRITE: begin
                    wr_en <= 1'b0;
                    state <= IDLE;
                end
                READ_WAIT: begin
                    rd_en    <= 1'b0;
                    rd_issue <= 1'b0;
                    if (rd_valid) begin
                        if (cmd_op == memop_pkg::OP_ADD) begin
                            state <= ADD_WRITE;
                            wr_en <= 1'b1;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                ADD_WRITE: begin
                    wr_en <= 1'b0;
                    state <= IDLE;
                end
                FILL: begin
                    if (fill_left == '0) begin
                        wr_en <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // addresses, write data, fill counter
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if ((state == IDLE) && cmd_valid) begin
            wr_addr   <= cmd_addr;
            rd_addr   <= cmd_addr;
            wr_din    <= cmd_data;
            fill_left <= (cmd_len == '0) ? '0 : cmd_len - 1'b1;
        end else if ((state == READ_WAIT) && rd_valid) begin
            // sum truncates to DATA_WIDTH
            wr_din <= rd_data + cmd_data;
        end else if ((state == FILL) && (fill_left != '0)) begin
            wr_addr   <= wr_addr + 1'b1;
            fill_left <= fill_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: memop_engine/memop_result.sv
// Aligns read data with the RAM latency of 1 + DOUT_REGS cycles.
// rd_data is only meaningful while rd_valid is high.
`timescale 1ns/1ps
`default_nettype none

module memop_result #(
    parameter int DATA_WIDTH = 32,
    parameter int DOUT_REGS  = 0
) (
    input  logic                  rd_clk,
    input  logic                  rst_n,

    // from execute and RAM
    input  logic                  rd_issue,
    input  logic [DATA_WIDTH-1:0] rd_dout,

    // aligned read result
    output logic                  rd_valid,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic [DATA_WIDTH-1:0] last_rdata
);

    // one stage per cycle of read latency
    logic [DOUT_REGS:0] issue_sr;

    // ----------------------------------------
    // latency shift
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            issue_sr <= '0;
        end else begin
            issue_sr[0] <= rd_issue;
            for (int i = 1; i <= DOUT_REGS; i++) begin
                issue_sr[i] <= issue_sr[i-1];
            end
        end
    end

    // last stage set means rd_dout holds the word just read
    assign rd_valid = issue_sr[DOUT_REGS];
    assign rd_data  = rd_dout;

    // ----------------------------------------
    // last-read register for the host
    // ----------------------------------------
    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            last_rdata <= '0;
        end else if (rd_valid) begin
            last_rdata <= rd_dout;
        end
    end

endmodule

`default_nettype wire

// File: src/memop_top.sv
// Memory operation engine behind an APB slave.
// Both RAM clocks run from rd_clk. ADDR_WIDTH up to 8, DATA_WIDTH up to 32.
`timescale 1ns/1ps
`default_nettype none

module memop_top #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32,
    parameter int DOUT_REGS  = 0
) (
    input  logic                                 rd_clk,
    input  logic                                 rst_n,

    // APB
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [3:0]                           paddr,
    input  logic [memop_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [memop_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    // ----------------------------------------
    // internal wiring
    // ----------------------------------------
    logic                                cmd_valid;
    memop_pkg::memop_opcode_e            cmd_op;
    logic [ADDR_WIDTH-1:0]               cmd_addr;
    logic [memop_pkg::CMD_LEN_WIDTH-1:0] cmd_len;
    logic [DATA_WIDTH-1:0]               cmd_data;
    logic                                busy;

    logic                                wr_en;
    logic [ADDR_WIDTH-1:0]               wr_addr;
    logic [DATA_WIDTH-1:0]               wr_din;
    logic                                rd_en;
    logic [ADDR_WIDTH-1:0]               rd_addr;
    logic                                rd_regcke;
    logic [DATA_WIDTH-1:0]               rd_dout;

    logic                                rd_issue;
    logic                                rd_valid;
    logic [DATA_WIDTH-1:0]               rd_data;
    logic [DATA_WIDTH-1:0]               last_rdata;

    memop_decode #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) decode_i (
        .rd_clk     (rd_clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .last_rdata (last_rdata),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_len    (cmd_len),
        .cmd_data   (cmd_data)
    );

    memop_execute #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) execute_i (
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .cmd_data  (cmd_data),
        .busy      (busy),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_din    (wr_din),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_regcke (rd_regcke),
        .rd_issue  (rd_issue),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    memop_result #(
        .DATA_WIDTH (DATA_WIDTH),
        .DOUT_REGS  (DOUT_REGS)
    ) result_i (
        .rd_clk     (rd_clk),
        .rst_n      (rst_n),
        .rd_issue   (rd_issue),
        .rd_dout    (rd_dout),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .last_rdata (last_rdata)
    );

    // memory starts cleared
    ram_simple_dualport #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH),
        .DOUT_REGS    (DOUT_REGS),
        .FILLMEM      (1'b1),
        .FILLMEM_DATA ('0)
    ) ram_i (
        .wr_clk    (rd_clk),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_din    (wr_din),
        .rd_clk    (rd_clk),
        .rd_en     (rd_en),
        .rd_regcke (rd_regcke),
        .rd_addr   (rd_addr),
        .rd_dout   (rd_dout)
    );

endmodule

`default_nettype wire

// File: sim/memop_tb.sv
// Testbench for memop_top with ADDR_WIDTH 6, DATA_WIDTH 16 and the RAM output register on.
// Each table row is one command: operand to REG_WDATA, command to REG_CMD, then busy polling.
`timescale 1ns/1ps

module memop_tb;

    localparam int ADDR_WIDTH   = 6;
    localparam int DATA_WIDTH   = 16;
    localparam int DOUT_REGS    = 1;
    localparam int MEM_SIZE     = 1 << ADDR_WIDTH;
    localparam int NUM_ROWS     = 22;
    localparam int RESET_CYCLES = 8;

    // row check kinds
    localparam int CHK_NONE   = 0;
    localparam int CHK_DATA   = 1;
    localparam int CHK_REJECT = 2;

    logic        rd_clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // stimulus table
    string                    row_name  [NUM_ROWS];
    memop_pkg::memop_opcode_e row_op    [NUM_ROWS];
    logic [ADDR_WIDTH-1:0]    row_addr  [NUM_ROWS];
    logic [15:0]              row_len   [NUM_ROWS];
    logic [DATA_WIDTH-1:0]    row_data  [NUM_ROWS];
    int                       row_check [NUM_ROWS];
    int                       row_count;

    // reference memory, RAM starts cleared
    logic [DATA_WIDTH-1:0]    model [MEM_SIZE];

    integer seed;
    int     error_count;
    int     check_count;

    memop_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .DOUT_REGS  (DOUT_REGS)
    ) dut_i (
        .rd_clk  (rd_clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 rd_clk = ~rd_clk;

    // ----------------------------------------
    // APB driver
    // ----------------------------------------
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge rd_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge rd_clk);
        #1;
        penable = 1'b1;
        // mid access cycle, response is settled
        #2;
        err = pslverr;
        compare_word("apb_write pready", 32'd1, {31'd0, pready});
        @(posedge rd_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge rd_clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge rd_clk);
        #1;
        penable = 1'b1;
        #2;
        data = prdata;
        compare_word("apb_read pready", 32'd1, {31'd0, pready});
        @(posedge rd_clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        do begin
            apb_read(memop_pkg::REG_STATUS, status);
        end while (status[0]);
    endtask

    // ----------------------------------------
    // table, model and checks
    // ----------------------------------------
    task automatic add_row(input string name, input memop_pkg::memop_opcode_e op,
                           input int addr, input int len, input int check);
        row_name[row_count]  = name;
        row_op[row_count]    = op;
        row_addr[row_count]  = addr[ADDR_WIDTH-1:0];
        row_len[row_count]   = len[15:0];
        row_data[row_count]  = $random(seed);
        row_check[row_count] = check;
        row_count++;
    endtask

    function automatic logic [31:0] make_command(input memop_pkg::memop_opcode_e op,
                                                 input logic [ADDR_WIDTH-1:0] addr,
                                                 input logic [15:0] len);
        logic [31:0] word;
        word = '0;
        word[memop_pkg::CMD_OP_LSB +: 2]            = op;
        word[memop_pkg::CMD_ADDR_LSB +: ADDR_WIDTH] = addr;
        word[memop_pkg::CMD_LEN_LSB +: 16]          = len;
        return word;
    endfunction

    task automatic update_model(input int r);
        int n;
        case (row_op[r])
            memop_pkg::OP_WRITE: begin
                model[row_addr[r]] = row_data[r];
            end
            memop_pkg::OP_ADD: begin
                model[row_addr[r]] = model[row_addr[r]] + row_data[r];
            end
            memop_pkg::OP_FILL: begin
                // zero length still writes one word
                n = (row_len[r] == 0) ? 1 : int'(row_len[r]);
                for (int i = 0; i < n; i++) begin
                    model[(int'(row_addr[r]) + i) % MEM_SIZE] = row_data[r];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic run_row(input int r);
        logic                  err;
        logic [31:0]           rdata;
        logic [DATA_WIDTH-1:0] old_word;
        logic [ADDR_WIDTH-1:0] extra_addr;
        old_word = model[row_addr[r]];
        apb_write(memop_pkg::REG_WDATA, {{(32-DATA_WIDTH){1'b0}}, row_data[r]}, err);
        apb_write(memop_pkg::REG_CMD, make_command(row_op[r], row_addr[r], row_len[r]), err);
        compare_word({row_name[r], " accept"}, 32'd0, {31'd0, err});
        update_model(r);
        if (row_check[r] == CHK_REJECT) begin
            // second command while the fill runs, aimed just past the fill
            extra_addr = row_addr[r] + row_len[r][ADDR_WIDTH-1:0];
            apb_write(memop_pkg::REG_CMD, make_command(memop_pkg::OP_WRITE, extra_addr, 16'd0),
                      err);
            compare_word({row_name[r], " pslverr"}, 32'd1, {31'd0, err});
        end
        wait_idle();
        if (row_check[r] == CHK_DATA) begin
            // read and add both return the word as it was before the command
            apb_read(memop_pkg::REG_RDATA, rdata);
            compare_word(row_name[r], {{(32-DATA_WIDTH){1'b0}}, old_word}, rdata);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rdata;
        rd_clk      = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        seed        = 38;
        row_count   = 0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            model[i] = '0;
        end

        add_row("rd_unwritten",    memop_pkg::OP_READ,  12, 0,  CHK_DATA);
        add_row("wr_a",            memop_pkg::OP_WRITE, 5,  0,  CHK_NONE);
        add_row("rd_a",            memop_pkg::OP_READ,  5,  0,  CHK_DATA);
        add_row("wr_b",            memop_pkg::OP_WRITE, 63, 0,  CHK_NONE);
        add_row("rd_b",            memop_pkg::OP_READ,  63, 0,  CHK_DATA);
        add_row("add_a",           memop_pkg::OP_ADD,   5,  0,  CHK_DATA);
        add_row("add_a_again",     memop_pkg::OP_ADD,   5,  0,  CHK_DATA);
        add_row("rd_add",          memop_pkg::OP_READ,  5,  0,  CHK_DATA);
        add_row("add_fresh",       memop_pkg::OP_ADD,   9,  0,  CHK_DATA);
        add_row("rd_fresh",        memop_pkg::OP_READ,  9,  0,  CHK_DATA);
        add_row("fill_wrap",       memop_pkg::OP_FILL,  60, 8,  CHK_NONE);
        add_row("rd_fill_first",   memop_pkg::OP_READ,  60, 0,  CHK_DATA);
        add_row("rd_fill_last",    memop_pkg::OP_READ,  3,  0,  CHK_DATA);
        add_row("rd_fill_after",   memop_pkg::OP_READ,  4,  0,  CHK_DATA);
        add_row("fill_zero_len",   memop_pkg::OP_FILL,  20, 0,  CHK_NONE);
        add_row("rd_fill_one",     memop_pkg::OP_READ,  20, 0,  CHK_DATA);
        add_row("rd_fill_next",    memop_pkg::OP_READ,  21, 0,  CHK_DATA);
        add_row("fill_reject",     memop_pkg::OP_FILL,  30, 20, CHK_REJECT);
        add_row("rd_reject_addr",  memop_pkg::OP_READ,  50, 0,  CHK_DATA);
        add_row("rd_reject_last",  memop_pkg::OP_READ,  49, 0,  CHK_DATA);
        add_row("rd_reject_first", memop_pkg::OP_READ,  30, 0,  CHK_DATA);
        add_row("rd_a_final",      memop_pkg::OP_READ,  5,  0,  CHK_DATA);

        repeat (RESET_CYCLES) @(posedge rd_clk);
        #1;
        rst_n = 1'b1;

        // state straight out of reset
        apb_read(memop_pkg::REG_STATUS, rdata);
        compare_word("reset_status", 32'd0, rdata);
        apb_read(memop_pkg::REG_RDATA, rdata);
        compare_word("reset_rdata", 32'd0, rdata);

        for (int r = 0; r < row_count; r++) begin
            run_row(r);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, generous per row
    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * 200) @(posedge rd_clk);
        $display("timeout: the command table did not finish within %0d cycles",
                 RESET_CYCLES + NUM_ROWS * 200);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: flist.f
common/memop_pkg.sv
src/ram_simple_dualport.sv
memop_engine/memop_decode.sv
memop_engine/memop_execute.sv
memop_engine/memop_result.sv
src/memop_top.sv
sim/memop_tb.sv

// File: Bender.yml
package:
  name: memop

sources:
  - common/memop_pkg.sv
  - src/ram_simple_dualport.sv
  - memop_engine/memop_decode.sv
  - memop_engine/memop_execute.sv
  - memop_engine/memop_result.sv
  - src/memop_top.sv
  - target: simulation
    files:
      - sim/memop_tb.sv
